// File: verilog/decimator_macros.svh
// Sizes are fixed at build time. Ratio exponents above DECIM_MAX_RATIO_LOG2 are not supported
`ifndef DECIMATOR_MACROS_SVH
`define DECIMATOR_MACROS_SVH

// Number of independent channels
`define DECIM_CHANNELS 6

// Width of a dest tag
// Must be wide enough for DECIM_CHANNELS
`define DECIM_CHANNEL_WIDTH 3

// Signed sample width on both the input and the output stream
`define DECIM_DATA_WIDTH 16

// Largest frame length is 2**DECIM_MAX_RATIO_LOG2 samples
// Also sets the growth bits of the frame sum
`define DECIM_MAX_RATIO_LOG2 4

`endif

// File: verilog/decimator_types_pkg.sv
// Datapath widths follow the macros. The sum width covers a full frame at the largest ratio only
`default_nettype none

`include "decimator_macros.svh"

package decimator_types_pkg;

    // One signed sample as it arrives and as it leaves
    typedef logic signed [`DECIM_DATA_WIDTH-1:0] sample_t;

    // Channel tag carried beside each sample
    typedef logic [`DECIM_CHANNEL_WIDTH-1:0] channel_t;

    // Frame sum
    // Sample width plus growth bits so a full frame cannot wrap
    typedef logic signed [`DECIM_DATA_WIDTH+`DECIM_MAX_RATIO_LOG2-1:0] sum_t;

    // Exponent of the decimation ratio
    // 3 bits reach 7 but only 0 to DECIM_MAX_RATIO_LOG2 are legal
    typedef logic [2:0] ratio_log2_t;

    // Position inside a frame
    typedef logic [`DECIM_MAX_RATIO_LOG2-1:0] phase_t;

endpackage

`default_nettype wire

// File: verilog/decimator_ctrl_pkg.sv
// Mode must be held steady from reset onward. Changing it mid-frame gives an undefined result
`default_nettype none

package decimator_ctrl_pkg;

    // Operating mode of the decimator
    // Pick keeps the last sample of a frame
    // Average returns the frame sum divided by the ratio
    typedef enum logic {
        MODE_PICK    = 1'b0,
        MODE_AVERAGE = 1'b1
    } mode_t;

    // Occupancy of the one-entry output register
    typedef enum logic {
        STAGE_EMPTY = 1'b0,
        STAGE_FULL  = 1'b1
    } stage_state_t;

endpackage

`default_nettype wire

// File: verilog/sample_stream_if.sv
// Valid/ready stream. The source holds data, dest and valid steady until ready is seen high
`timescale 1ns/1ps
`default_nettype none

`include "decimator_macros.svh"

interface sample_stream_if #(
    parameter int DATA_WIDTH = `DECIM_DATA_WIDTH
);

    // Payload and tag
    logic signed [DATA_WIDTH-1:0]    data;
    decimator_types_pkg::channel_t   dest;

    // Handshake
    // A transfer happens on a rising edge with both high
    logic                            valid;
    logic                            ready;

    // Producer side
    modport source (output data, output dest, output valid, input ready);

    // Consumer side
    modport sink (input data, input dest, input valid, output ready);

endinterface

`default_nettype wire

// File: verilog/phase_counter_bank.sv
// Counters only move for in-range channels. A reset puts every channel at the start of a frame
`timescale 1ns/1ps
`default_nettype none

`include "decimator_macros.svh"

module phase_counter_bank (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             advance,
    input  decimator_types_pkg::channel_t    channel,
    input  decimator_types_pkg::ratio_log2_t ratio_log2,
    output logic                             frame_last
);

    // One phase counter per channel
    decimator_types_pkg::phase_t phase_q [`DECIM_CHANNELS];

    // Counter of the addressed channel
    decimator_types_pkg::phase_t phase_sel;
    // Phase value of the final sample in a frame
    decimator_types_pkg::phase_t last_phase;
    logic                        in_range;

    // Tags 6 and 7 have no counter
    assign in_range = channel < decimator_types_pkg::channel_t'(`DECIM_CHANNELS);

    // Frame length minus one
    // 2**4 - 1 still fits the 4-bit phase
    assign last_phase = decimator_types_pkg::phase_t'((32'd1 << ratio_log2) - 32'd1);

    // Keep the array index legal
    assign phase_sel = in_range ? phase_q[channel] : '0;

    // Same cycle as the sample it describes
    assign frame_last = in_range && (phase_sel == last_phase);

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `DECIM_CHANNELS; i++) begin
                phase_q[i] <= '0;
            end
        end else if (advance && in_range) begin
            // Wrap on the last sample of the frame
            if (frame_last) begin
                phase_q[channel] <= '0;
            end else begin
                phase_q[channel] <= phase_sel + decimator_types_pkg::phase_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/channel_accumulator.sv
// Out-of-range dest samples are accepted and dropped. Ratio and mode must not change mid-frame
`timescale 1ns/1ps
`default_nettype none

`include "decimator_macros.svh"

module channel_accumulator (
    input  logic                             clock,
    input  logic                             reset,
    input  decimator_types_pkg::sample_t     in_data,
    input  decimator_types_pkg::channel_t    in_dest,
    input  logic                             in_valid,
    output logic                             in_ready,
    input  decimator_ctrl_pkg::mode_t        mode,
    input  decimator_types_pkg::ratio_log2_t ratio_log2,
    sample_stream_if.source                  result
);

    // Running sum per channel
    decimator_types_pkg::sum_t sum_q [`DECIM_CHANNELS];

    // Sum of the addressed channel
    decimator_types_pkg::sum_t sum_sel;
    // That sum with the incoming sample added
    decimator_types_pkg::sum_t sum_next;
    // Sample widened to the sum width
    decimator_types_pkg::sum_t sample_ext;

    logic in_range;
    logic accept;
    logic advance;
    logic frame_last;

    // Input stalls only while a finished result is waiting downstream
    assign in_ready = !result.valid || result.ready;
    assign accept   = in_valid && in_ready;

    assign in_range = in_dest < decimator_types_pkg::channel_t'(`DECIM_CHANNELS);

    // Only in-range samples touch a counter or a sum
    assign advance = accept && in_range;

    // Sign extension keeps negative samples negative
    assign sample_ext = decimator_types_pkg::sum_t'(in_data);

    assign sum_sel  = in_range ? sum_q[in_dest] : '0;
    assign sum_next = sum_sel + sample_ext;

    // Frame position tracking
    phase_counter_bank phase0 (
        .clock      (clock),
        .reset      (reset),
        .advance    (advance),
        .channel    (in_dest),
        .ratio_log2 (ratio_log2),
        .frame_last (frame_last)
    );

    // Per-channel sums
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `DECIM_CHANNELS; i++) begin
                sum_q[i] <= '0;
            end
        end else if (advance) begin
            // Start the next frame from zero
            if (frame_last) begin
                sum_q[in_dest] <= '0;
            end else begin
                sum_q[in_dest] <= sum_next;
            end
        end
    end

    // Result handshake state
    always_ff @(posedge clock) begin
        if (reset) begin
            result.valid <= 1'b0;
        end else if (advance && frame_last) begin
            // New result may land in the same cycle the old one drains
            result.valid <= 1'b1;
        end else if (result.ready) begin
            result.valid <= 1'b0;
        end
    end

    // Result payload
    always_ff @(posedge clock) begin
        if (advance && frame_last) begin
            // Picking mode forwards the closing sample as is
            if (mode == decimator_ctrl_pkg::MODE_AVERAGE) begin
                result.data <= sum_next;
            end else begin
                result.data <= sample_ext;
            end
            result.dest <= in_dest;
        end
    end

endmodule

`default_nettype wire

// File: verilog/average_output_stage.sv
// Averaging shifts toward minus infinity. Mode and ratio must match those used by the accumulator
`timescale 1ns/1ps
`default_nettype none

module average_output_stage (
    input  logic                             clock,
    input  logic                             reset,
    input  decimator_ctrl_pkg::mode_t        mode,
    input  decimator_types_pkg::ratio_log2_t ratio_log2,
    sample_stream_if.sink                    result,
    output decimator_types_pkg::sample_t     out_data,
    output decimator_types_pkg::channel_t    out_dest,
    output logic                             out_valid,
    input  logic                             out_ready
);

    // Occupancy of the output register
    decimator_ctrl_pkg::stage_state_t state_q;

    // Sum after division by the ratio
    decimator_types_pkg::sum_t shifted;
    // Value narrowed to the sample width
    decimator_types_pkg::sample_t scaled;

    logic load;

    // Arithmetic shift on a signed sum
    assign shifted = result.data >>> ratio_log2;

    // Average of a frame always fits a sample
    // Picked sample arrives sign-extended so the low bits are exact
    assign scaled = (mode == decimator_ctrl_pkg::MODE_AVERAGE)
                  ? decimator_types_pkg::sample_t'(shifted)
                  : decimator_types_pkg::sample_t'(result.data);

    // Take a new result when empty or when the current one leaves this cycle
    assign result.ready = (state_q == decimator_ctrl_pkg::STAGE_EMPTY) || out_ready;
    assign load         = result.valid && result.ready;

    assign out_valid = (state_q == decimator_ctrl_pkg::STAGE_FULL);

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q <= decimator_ctrl_pkg::STAGE_EMPTY;
        end else if (load) begin
            state_q <= decimator_ctrl_pkg::STAGE_FULL;
        end else if (out_ready) begin
            // Drained with nothing behind it
            state_q <= decimator_ctrl_pkg::STAGE_EMPTY;
        end
    end

    // Output payload
    always_ff @(posedge clock) begin
        if (load) begin
            out_data <= scaled;
            out_dest <= result.dest;
        end
    end

endmodule

`default_nettype wire

// File: verilog/decimator_top.sv
// Ratio is a power of two up to 16. Hold mode and ratio_log2 steady from reset onward
`timescale 1ns/1ps
`default_nettype none

module decimator_top (
    input  logic                             clock,
    input  logic                             reset,
    input  decimator_ctrl_pkg::mode_t        mode,
    input  decimator_types_pkg::ratio_log2_t ratio_log2,
    input  decimator_types_pkg::sample_t     in_data,
    input  decimator_types_pkg::channel_t    in_dest,
    input  logic                             in_valid,
    output logic                             in_ready,
    output decimator_types_pkg::sample_t     out_data,
    output decimator_types_pkg::channel_t    out_dest,
    output logic                             out_valid,
    input  logic                             out_ready
);

    // Incoming sample stream
    sample_stream_if #(.DATA_WIDTH($bits(decimator_types_pkg::sample_t))) in_stream ();

    // Raw frame results at full sum width
    sample_stream_if #(.DATA_WIDTH($bits(decimator_types_pkg::sum_t))) result_stream ();

    assign in_stream.data  = in_data;
    assign in_stream.dest  = in_dest;
    assign in_stream.valid = in_valid;
    assign in_ready        = in_stream.ready;

    // Per-channel sums and frame detection
    channel_accumulator accum0 (
        .clock      (clock),
        .reset      (reset),
        .in_data    (in_stream.data),
        .in_dest    (in_stream.dest),
        .in_valid   (in_stream.valid),
        .in_ready   (in_stream.ready),
        .mode       (mode),
        .ratio_log2 (ratio_log2),
        .result     (result_stream.source)
    );

    // Scaling and output register
    average_output_stage stage0 (
        .clock      (clock),
        .reset      (reset),
        .mode       (mode),
        .ratio_log2 (ratio_log2),
        .result     (result_stream.sink),
        .out_data   (out_data),
        .out_dest   (out_dest),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

endmodule

`default_nettype wire

// File: tb/decimator_tb.sv
// Each group resets the DUT and holds mode and ratio fixed. out_ready stalls at random throughout
`timescale 1ns/1ps
`default_nettype none

`include "decimator_macros.svh"

module decimator_tb;

    logic                             clock;
    logic                             reset;
    decimator_ctrl_pkg::mode_t        mode;
    decimator_types_pkg::ratio_log2_t ratio_log2;
    decimator_types_pkg::sample_t     in_data;
    decimator_types_pkg::channel_t    in_dest;
    logic                             in_valid;
    logic                             in_ready;
    decimator_types_pkg::sample_t     out_data;
    decimator_types_pkg::channel_t    out_dest;
    logic                             out_valid;
    logic                             out_ready;

    // Stimulus table
    int                               row_count;
    int                               row_group [160];
    decimator_ctrl_pkg::mode_t        row_mode  [160];
    decimator_types_pkg::ratio_log2_t row_ratio [160];
    decimator_types_pkg::channel_t    row_dest  [160];
    decimator_types_pkg::sample_t     row_data  [160];

    // Reference model state
    int                               model_sum   [`DECIM_CHANNELS];
    int                               model_count [`DECIM_CHANNELS];
    decimator_types_pkg::sample_t     exp_data_q [$];
    decimator_types_pkg::channel_t    exp_dest_q [$];

    int group_checks;
    int group_errors;
    int total_checks;
    int total_errors;
    int group_total;
    int cycle_count;
    int cycle_limit;
    int seed_word;
    int cur_group;

    decimator_top dut0 (
        .clock      (clock),
        .reset      (reset),
        .mode       (mode),
        .ratio_log2 (ratio_log2),
        .in_data    (in_data),
        .in_dest    (in_dest),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .out_data   (out_data),
        .out_dest   (out_dest),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

    always #2 clock = ~clock;

    task automatic add_row(input int group, input decimator_ctrl_pkg::mode_t m,
                           input decimator_types_pkg::ratio_log2_t r,
                           input decimator_types_pkg::channel_t d,
                           input decimator_types_pkg::sample_t v);
        row_group[row_count] = group;
        row_mode[row_count]  = m;
        row_ratio[row_count] = r;
        row_dest[row_count]  = d;
        row_data[row_count]  = v;
        row_count++;
    endtask

    task automatic build_table();
        // Channel 3 averages: -4, then full-scale positive and negative frames
        add_row(0, decimator_ctrl_pkg::MODE_AVERAGE, 2, 3, -10);
        add_row(0, decimator_ctrl_pkg::MODE_AVERAGE, 2, 3, -7);
        add_row(0, decimator_ctrl_pkg::MODE_AVERAGE, 2, 3, -3);
        add_row(0, decimator_ctrl_pkg::MODE_AVERAGE, 2, 3, 4);
        for (int i = 0; i < 4; i++) begin
            add_row(0, decimator_ctrl_pkg::MODE_AVERAGE, 2, 3, 16'h7fff);
        end
        for (int i = 0; i < 4; i++) begin
            add_row(0, decimator_ctrl_pkg::MODE_AVERAGE, 2, 3, 16'h8000);
        end
        // Picking at ratio 8
        for (int i = 0; i < 16; i++) begin
            add_row(1, decimator_ctrl_pkg::MODE_PICK, 3, 1, i * 1000 - 7000);
        end
        // Six channels in mixed order at ratio 2
        for (int i = 0; i < 24; i++) begin
            add_row(2, decimator_ctrl_pkg::MODE_AVERAGE, 1, (i * 5) % 6, i * 37 - 300);
        end
        // Out-of-range tags inside a channel 0 frame
        add_row(3, decimator_ctrl_pkg::MODE_AVERAGE, 2, 0, 100);
        add_row(3, decimator_ctrl_pkg::MODE_AVERAGE, 2, 6, 500);
        add_row(3, decimator_ctrl_pkg::MODE_AVERAGE, 2, 0, 200);
        add_row(3, decimator_ctrl_pkg::MODE_AVERAGE, 2, 7, -900);
        add_row(3, decimator_ctrl_pkg::MODE_AVERAGE, 2, 6, 16'h7fff);
        add_row(3, decimator_ctrl_pkg::MODE_AVERAGE, 2, 0, 300);
        add_row(3, decimator_ctrl_pkg::MODE_AVERAGE, 2, 0, 400);
        add_row(3, decimator_ctrl_pkg::MODE_AVERAGE, 2, 7, 55);
        // Random data and tags, mostly to exercise stalls
        for (int i = 0; i < 32; i++) begin
            add_row(4, decimator_ctrl_pkg::MODE_AVERAGE, 1, $urandom % 6, $urandom);
        end
        // Ratio 1 passes samples through in both modes
        for (int i = 0; i < 6; i++) begin
            add_row(5, decimator_ctrl_pkg::MODE_AVERAGE, 0, i, i * 4099 - 9000);
        end
        for (int i = 0; i < 6; i++) begin
            add_row(6, decimator_ctrl_pkg::MODE_PICK, 0, 5 - i, -i * 3001);
        end
    endtask

    // Model of one accepted sample
    task automatic model_accept(input int i);
        int d;
        d = row_dest[i];
        if (d < `DECIM_CHANNELS) begin
            model_sum[d] += row_data[i];
            model_count[d]++;
            if (model_count[d] == (1 << row_ratio[i])) begin
                // Arithmetic shift rounds toward minus infinity
                if (row_mode[i] == decimator_ctrl_pkg::MODE_AVERAGE) begin
                    exp_data_q.push_back(
                        decimator_types_pkg::sample_t'(model_sum[d] >>> row_ratio[i]));
                end else begin
                    exp_data_q.push_back(row_data[i]);
                end
                exp_dest_q.push_back(row_dest[i]);
                model_sum[d]   = 0;
                model_count[d] = 0;
            end
        end
    endtask

    task automatic start_group(input decimator_ctrl_pkg::mode_t m,
                               input decimator_types_pkg::ratio_log2_t r);
        reset      = 1'b1;
        in_valid   = 1'b0;
        mode       = m;
        ratio_log2 = r;
        for (int c = 0; c < `DECIM_CHANNELS; c++) begin
            model_sum[c]   = 0;
            model_count[c] = 0;
        end
        group_checks = 0;
        group_errors = 0;
        repeat (8) @(posedge clock);
        #1 reset = 1'b0;
        // Both stream registers leave reset empty
        assert (in_ready) else begin
            $display("MISMATCH in_ready: got %h expected %h", in_ready, 1'b1);
            group_errors++;
        end
        assert (!out_valid) else begin
            $display("MISMATCH out_valid: got %h expected %h", out_valid, 1'b0);
            group_errors++;
        end
    endtask

    // Called 1 ns after an edge, returns 1 ns after the accepting edge
    task automatic send_row(input int i);
        in_valid = 1'b1;
        in_data  = row_data[i];
        in_dest  = row_dest[i];
        #1;
        while (!in_ready) begin
            @(posedge clock);
            #2;
        end
        @(posedge clock);
        #1;
        // The sample went in on the edge just passed
        model_accept(i);
    endtask

    task automatic finish_group();
        in_valid = 1'b0;
        while (exp_data_q.size() != 0) @(posedge clock);
        // A few idle cycles to catch stray outputs
        repeat (4) @(posedge clock);
        #1;
        $display("Group %0d: %0d results checked, %0d errors",
                 cur_group, group_checks, group_errors);
        total_checks += group_checks;
        total_errors += group_errors;
        group_total++;
    endtask

    task automatic check_output();
        assert (exp_data_q.size() != 0) else begin
            $display("Unexpected output with no frame pending, dest %0d data %h",
                     out_dest, out_data);
            group_errors++;
        end
        if (exp_data_q.size() != 0) begin
            group_checks++;
            assert (out_data == exp_data_q[0]) else begin
                $display("MISMATCH out_data: got %h expected %h", out_data, exp_data_q[0]);
                group_errors++;
            end
            assert (out_dest == exp_dest_q[0]) else begin
                $display("MISMATCH out_dest: got %h expected %h", out_dest, exp_dest_q[0]);
                group_errors++;
            end
            void'(exp_data_q.pop_front());
            void'(exp_dest_q.pop_front());
        end
    endtask

    // Random out_ready, then sample a transfer that the next edge completes
    always @(posedge clock) begin
        #1 out_ready = (($urandom % 4) != 0);
        #1;
        if (!reset && out_valid && out_ready) check_output();
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_limit != 0 && cycle_count > cycle_limit) begin
            $display("Timeout: run exceeded %0d cycles", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        clock        = 1'b0;
        reset        = 1'b1;
        mode         = decimator_ctrl_pkg::MODE_AVERAGE;
        ratio_log2   = '0;
        in_data      = '0;
        in_dest      = '0;
        in_valid     = 1'b0;
        out_ready    = 1'b0;
        row_count    = 0;
        total_checks = 0;
        total_errors = 0;
        group_total  = 0;
        cycle_count  = 0;
        cycle_limit  = 0;
        cur_group    = -1;
        seed_word    = $urandom(32'h5668_2fa2);
        build_table();
        // 7 groups, each with 8 reset cycles
        cycle_limit = row_count * 20 + 7 * 8;
        @(posedge clock);
        #1;
        for (int i = 0; i < row_count; i++) begin
            if (row_group[i] != cur_group) begin
                if (cur_group >= 0) finish_group();
                cur_group = row_group[i];
                start_group(row_mode[i], row_ratio[i]);
            end
            send_row(i);
        end
        finish_group();
        $display("Summary: %0d groups, %0d results checked, %0d errors",
                 group_total, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: decimator.f
+incdir+verilog
verilog/decimator_types_pkg.sv
verilog/decimator_ctrl_pkg.sv
verilog/sample_stream_if.sv
verilog/phase_counter_bank.sv
verilog/channel_accumulator.sv
verilog/average_output_stage.sv
verilog/decimator_top.sv
tb/decimator_tb.sv
